//--- sources.f
hw/axi_pkg.sv
hw/mem_pkg.sv
hw/mem_arbiter.sv
hw/axi_master_bridge.sv
hw/axi_slave_mem.sv
hw/mem_top.sv
testbench/mem_top_checker.sv
testbench/tb_mem_top.sv

//--- run.sh
#!/bin/sh
# build and run the memory testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_mem_top -f sources.f -o sim_mem_top || exit 1

out=$(./obj_dir/sim_mem_top)
echo "$out"
echo "$out" | grep -q "PASS: all tests" && echo "simulation passed" || {
    echo "simulation failed"
    exit 1
}

//--- testbench/tb_mem_top.sv
// memory subsystem testbench
`default_nettype none

module tb_mem_top
    import axi_pkg::*;
    import mem_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_TESTS = 6;
    localparam int RSP_WAIT  = 50;   // cycles allowed per response
    localparam int RAND_BASE = 64;   // first word of the random region
    localparam int RAND_SPAN = 8;
    localparam int RAND_OPS  = 24;

    logic      clk = 1'b0;
    logic      arst_n_i;
    logic      fetch_req_i;
    axi_addr_t fetch_addr_i;
    logic      fetch_rsp_o;
    line_t     fetch_line_o;
    logic      fetch_err_o;
    logic      data_req_i;
    logic      data_we_i;
    axi_addr_t data_addr_i;
    axi_data_t data_wdata_i;
    axi_strb_t data_wmask_i;
    logic      data_rsp_o;
    axi_data_t data_rdata_o;
    logic      data_err_o;

    axi_data_t ref_mem [MEM_WORDS];   // expected memory contents
    client_e   last_client;           // round-robin pointer model
    integer    seed;

    always #10 clk = ~clk;   // 20 ns period

    mem_top mem_top_i (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .fetch_req_i  (fetch_req_i),
        .fetch_addr_i (fetch_addr_i),
        .fetch_rsp_o  (fetch_rsp_o),
        .fetch_line_o (fetch_line_o),
        .fetch_err_o  (fetch_err_o),
        .data_req_i   (data_req_i),
        .data_we_i    (data_we_i),
        .data_addr_i  (data_addr_i),
        .data_wdata_i (data_wdata_i),
        .data_wmask_i (data_wmask_i),
        .data_rsp_o   (data_rsp_o),
        .data_rdata_o (data_rdata_o),
        .data_err_o   (data_err_o)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_eq(input string name, input line_t got, input line_t exp);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    // byte lanes under mask take the new data
    function automatic axi_data_t merge_bytes(axi_data_t old, axi_data_t data, axi_strb_t mask);
        axi_data_t res;
        res = old;
        for (int i = 0; i < AXI_STRB_W; i++) begin
            if (mask[i]) begin
                res[i*8 +: 8] = data[i*8 +: 8];
            end
        end
        return res;
    endfunction

    function automatic int word_at(axi_addr_t addr);
        return int'(addr / 8);
    endfunction

    function automatic logic out_of_range(axi_addr_t addr);
        return addr >= axi_addr_t'(MEM_WORDS * 8);   // 2048 and up
    endfunction

    function automatic axi_data_t rand_data();
        return {$random(seed), $random(seed)};
    endfunction

    // one data strobe, then wait for its response
    task automatic data_access(input logic we, input axi_addr_t addr, input axi_data_t wdata,
            input axi_strb_t mask, output axi_data_t rdata, output logic err);
        int waited;
        @(posedge clk);
        #2;
        data_req_i   = 1'b1;
        data_we_i    = we;
        data_addr_i  = addr;
        data_wdata_i = wdata;
        data_wmask_i = mask;
        @(posedge clk);
        #2;
        data_req_i = 1'b0;
        waited     = 0;
        @(negedge clk);
        while (!data_rsp_o) begin
            waited++;
            if (waited > RSP_WAIT) begin
                fail_run($sformatf("data response missing %0d cycles after strobe", RSP_WAIT));
            end
            @(negedge clk);
        end
        rdata       = data_rdata_o;
        err         = data_err_o;
        last_client = CLIENT_DATA;
    endtask

    task automatic fetch_access(input axi_addr_t addr, output line_t line, output logic err);
        int waited;
        @(posedge clk);
        #2;
        fetch_req_i  = 1'b1;
        fetch_addr_i = addr;
        @(posedge clk);
        #2;
        fetch_req_i = 1'b0;
        waited      = 0;
        @(negedge clk);
        while (!fetch_rsp_o) begin
            waited++;
            if (waited > RSP_WAIT) begin
                fail_run($sformatf("fetch response missing %0d cycles after strobe", RSP_WAIT));
            end
            @(negedge clk);
        end
        line        = fetch_line_o;
        err         = fetch_err_o;
        last_client = CLIENT_FETCH;
    endtask

    task automatic store_word(input axi_addr_t addr, input axi_data_t data, input axi_strb_t mask);
        axi_data_t rdata;
        logic      err;
        logic      bad;
        bad = out_of_range(addr);
        data_access(1'b1, addr, data, mask, rdata, err);
        check_eq("data_err_o", line_t'(err), line_t'(bad));
        check_eq("data_rdata_o", line_t'(rdata), '0);   // stores answer zero
        if (!bad) begin
            ref_mem[word_at(addr)] = merge_bytes(ref_mem[word_at(addr)], data, mask);
        end
    endtask

    task automatic load_word(input axi_addr_t addr);
        axi_data_t rdata;
        axi_data_t exp;
        logic      err;
        logic      bad;
        bad = out_of_range(addr);
        exp = '0;
        if (!bad) begin
            exp = ref_mem[word_at(addr)];
        end
        data_access(1'b0, addr, '0, '0, rdata, err);
        check_eq("data_err_o", line_t'(err), line_t'(bad));
        check_eq("data_rdata_o", line_t'(rdata), line_t'(exp));
    endtask

    // line is two words, first one low
    task automatic fetch_line_check(input axi_addr_t addr);
        line_t line;
        logic  err;
        int    w;
        w = word_at(addr);
        fetch_access(addr, line, err);
        check_eq("fetch_err_o", line_t'(err), '0);
        check_eq("fetch_line_o", line, {ref_mem[w+1], ref_mem[w]});
    endtask

    // fetch and data load strobed in the same cycle
    task automatic contend(input axi_addr_t faddr, input axi_addr_t daddr);
        client_e   first;
        client_e   expect_first;
        logic      got_f;
        logic      got_d;
        line_t     fline;
        logic      ferr;
        axi_data_t drd;
        logic      derr;
        int        waited;
        int        w;
        expect_first = (last_client == CLIENT_DATA) ? CLIENT_FETCH : CLIENT_DATA;
        first  = CLIENT_FETCH;
        got_f  = 1'b0;
        got_d  = 1'b0;
        waited = 0;
        w      = word_at(faddr);
        @(posedge clk);
        #2;
        fetch_req_i  = 1'b1;
        fetch_addr_i = faddr;
        data_req_i   = 1'b1;
        data_we_i    = 1'b0;
        data_addr_i  = daddr;
        data_wmask_i = '0;
        @(posedge clk);
        #2;
        fetch_req_i = 1'b0;
        data_req_i  = 1'b0;
        while (!(got_f && got_d)) begin
            @(negedge clk);
            waited++;
            if (fetch_rsp_o) begin
                if (!got_d) first = CLIENT_FETCH;
                got_f = 1'b1;
                fline = fetch_line_o;
                ferr  = fetch_err_o;
            end
            if (data_rsp_o) begin
                if (!got_f) first = CLIENT_DATA;
                got_d = 1'b1;
                drd   = data_rdata_o;
                derr  = data_err_o;
            end
            if (waited > 2 * RSP_WAIT) begin
                fail_run("contending clients did not both get a response in time");
            end
        end
        check_eq("first response client", line_t'(first), line_t'(expect_first));
        check_eq("fetch_err_o", line_t'(ferr), '0);
        check_eq("fetch_line_o", fline, {ref_mem[w+1], ref_mem[w]});
        check_eq("data_err_o", line_t'(derr), '0);
        check_eq("data_rdata_o", line_t'(drd), line_t'(ref_mem[word_at(daddr)]));
        last_client = (first == CLIENT_FETCH) ? CLIENT_DATA : CLIENT_FETCH;   // loser went last
    endtask

    task automatic store_then_load();
        store_word(32'h0, rand_data(), 8'hFF);
        load_word(32'h0);
        store_word(32'h10, rand_data(), 8'hFF);
        load_word(32'h10);
    endtask

    task automatic partial_mask_store();
        store_word(32'h10, rand_data(), 8'h0F);
        load_word(32'h10);
        store_word(32'h10, rand_data(), 8'hA5);
        load_word(32'h10);
    endtask

    task automatic line_fetch();
        store_word(32'h20, rand_data(), 8'hFF);
        store_word(32'h28, rand_data(), 8'hFF);
        fetch_line_check(32'h20);
    endtask

    task automatic contention_order();
        store_word(32'h30, rand_data(), 8'hFF);   // data granted last
        contend(32'h20, 32'h30);
        fetch_line_check(32'h20);                 // fetch granted last
        contend(32'h20, 32'h0);
    endtask

    task automatic out_of_range_access();
        store_word(32'h800, rand_data(), 8'hFF);   // would alias word 0
        store_word(32'h810, rand_data(), 8'hFF);
        load_word(32'h808);
        load_word(32'hFFF8);
        load_word(32'h0);                          // untouched
        load_word(32'h10);
    endtask

    task automatic random_traffic();
        integer    rnd;
        axi_addr_t addr;
        for (int i = 0; i < RAND_SPAN; i++) begin
            store_word(axi_addr_t'((RAND_BASE + i) * 8), rand_data(), 8'hFF);
        end
        for (int n = 0; n < RAND_OPS; n++) begin
            rnd  = $random(seed);
            addr = axi_addr_t'((RAND_BASE + int'(rnd[2:0])) * 8);
            case (rnd[5:4])
                2'd0, 2'd1: store_word(addr, rand_data(), rnd[15:8]);
                2'd2:       load_word(addr);
                default:    fetch_line_check(axi_addr_t'((RAND_BASE + 2 * int'(rnd[2:1])) * 8));
            endcase
        end
    endtask

    // watchdog, 200 cycles per test
    initial begin
        repeat (NUM_TESTS * 200) @(posedge clk);
        fail_run("watchdog expired before the tests finished");
    end

    initial begin
        seed         = 73329;
        arst_n_i     = 1'b0;
        fetch_req_i  = 1'b0;
        fetch_addr_i = '0;
        data_req_i   = 1'b0;
        data_we_i    = 1'b0;
        data_addr_i  = '0;
        data_wdata_i = '0;
        data_wmask_i = '0;
        last_client  = CLIENT_DATA;   // fetch takes the first tie
        repeat (3) @(posedge clk);
        #2;
        arst_n_i = 1'b1;
        store_then_load();
        partial_mask_store();
        line_fetch();
        contention_order();
        out_of_range_access();
        random_traffic();
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/mem_top_checker.sv
// axi channel protocol checks
`default_nettype none

module mem_top_checker
    import axi_pkg::*;
(
    input wire       clk,
    input wire       arst_n_i,
    input wire       gnt_valid_i,
    input wire       busy_i,
    input wire       rsp_valid_i,
    input wire       ar_valid_i,
    input wire       ar_ready_i,
    input axi_ar_t   ar_i,
    input wire       aw_valid_i,
    input wire       aw_ready_i,
    input axi_aw_t   aw_i,
    input wire       w_valid_i,
    input wire       w_ready_i,
    input axi_w_t    w_i,
    input wire       r_valid_i,
    input wire       r_ready_i,
    input axi_r_t    r_i,
    input wire       b_valid_i,
    input wire       b_ready_i,
    input axi_resp_e b_resp_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // valid holds, payload frozen, until ready
    a_ar_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_i))
        else $error("read address valid dropped or payload moved before ready");
    a_aw_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        aw_valid_i && !aw_ready_i |=> aw_valid_i && $stable(aw_i))
        else $error("write address valid dropped or payload moved before ready");
    a_w_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        w_valid_i && !w_ready_i |=> w_valid_i && $stable(w_i))
        else $error("write data valid dropped or payload moved before ready");
    a_r_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        r_valid_i && !r_ready_i |=> r_valid_i && $stable(r_i))
        else $error("read data valid dropped or payload moved before ready");
    a_b_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        b_valid_i && !b_ready_i |=> b_valid_i && $stable(b_resp_i))
        else $error("write response valid dropped or resp moved before ready");

    // reads and writes never overlap
    a_ar_aw_excl: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(ar_valid_i && aw_valid_i))
        else $error("read and write address valid high together");
    a_gnt_idle: assert property (@(posedge clk) disable iff (!arst_n_i)
        gnt_valid_i |-> !busy_i)
        else $error("grant issued while the bridge was busy");
    a_rsp_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
        rsp_valid_i |=> !rsp_valid_i)
        else $error("response strobe longer than one cycle");

endmodule

bind axi_master_bridge mem_top_checker u_checker (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .gnt_valid_i (gnt_valid_i),
    .busy_i      (busy_o),
    .rsp_valid_i (rsp_valid_o),
    .ar_valid_i  (ar_valid_o),
    .ar_ready_i  (ar_ready_i),
    .ar_i        (ar_o),
    .aw_valid_i  (aw_valid_o),
    .aw_ready_i  (aw_ready_i),
    .aw_i        (aw_o),
    .w_valid_i   (w_valid_o),
    .w_ready_i   (w_ready_i),
    .w_i         (w_o),
    .r_valid_i   (r_valid_i),
    .r_ready_i   (r_ready_o),
    .r_i         (r_i),
    .b_valid_i   (b_valid_i),
    .b_ready_i   (b_ready_o),
    .b_resp_i    (b_resp_i)
);

`default_nettype wire

//--- hw/mem_top.sv
// memory subsystem top level
`default_nettype none

module mem_top
    import axi_pkg::*;
    import mem_pkg::*;
(
    input  wire       clk,
    input  wire       arst_n_i,
    input  wire       fetch_req_i,
    input  axi_addr_t fetch_addr_i,
    output logic      fetch_rsp_o,
    output line_t     fetch_line_o,
    output logic      fetch_err_o,
    input  wire       data_req_i,
    input  wire       data_we_i,
    input  axi_addr_t data_addr_i,
    input  axi_data_t data_wdata_i,
    input  axi_strb_t data_wmask_i,
    output logic      data_rsp_o,
    output axi_data_t data_rdata_o,
    output logic      data_err_o
);

    logic      gnt_valid;
    mem_req_t  gnt_req;
    logic      bridge_busy;
    logic      rsp_valid;
    mem_rsp_t  rsp;
    logic      ar_valid;
    logic      ar_ready;
    logic      r_valid;
    logic      r_ready;
    logic      aw_valid;
    logic      aw_ready;
    logic      w_valid;
    logic      w_ready;
    logic      b_valid;
    logic      b_ready;
    axi_ar_t   ar;
    axi_r_t    r;
    axi_aw_t   aw;
    axi_w_t    w;
    axi_resp_e b_resp;

    // response goes to the client named in it
    assign fetch_rsp_o  = rsp_valid && (rsp.client == CLIENT_FETCH);
    assign fetch_line_o = rsp.line;
    assign fetch_err_o  = rsp.err;
    assign data_rsp_o   = rsp_valid && (rsp.client == CLIENT_DATA);
    assign data_rdata_o = rsp.line[AXI_DATA_W-1:0];   // low beat only
    assign data_err_o   = rsp.err;

    mem_arbiter u_arbiter (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .fetch_req_i  (fetch_req_i),
        .fetch_addr_i (fetch_addr_i),
        .data_req_i   (data_req_i),
        .data_we_i    (data_we_i),
        .data_addr_i  (data_addr_i),
        .data_wdata_i (data_wdata_i),
        .data_wmask_i (data_wmask_i),
        .busy_i       (bridge_busy),
        .gnt_valid_o  (gnt_valid),
        .gnt_req_o    (gnt_req)
    );

    axi_master_bridge u_bridge (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .gnt_valid_i (gnt_valid),
        .gnt_req_i   (gnt_req),
        .ar_ready_i  (ar_ready),
        .r_valid_i   (r_valid),
        .r_i         (r),
        .aw_ready_i  (aw_ready),
        .w_ready_i   (w_ready),
        .b_valid_i   (b_valid),
        .b_resp_i    (b_resp),
        .busy_o      (bridge_busy),
        .rsp_valid_o (rsp_valid),
        .rsp_o       (rsp),
        .ar_valid_o  (ar_valid),
        .ar_o        (ar),
        .r_ready_o   (r_ready),
        .aw_valid_o  (aw_valid),
        .aw_o        (aw),
        .w_valid_o   (w_valid),
        .w_o         (w),
        .b_ready_o   (b_ready)
    );

    axi_slave_mem u_mem (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .ar_valid_i (ar_valid),
        .ar_i       (ar),
        .r_ready_i  (r_ready),
        .aw_valid_i (aw_valid),
        .aw_i       (aw),
        .w_valid_i  (w_valid),
        .w_i        (w),
        .b_ready_i  (b_ready),
        .ar_ready_o (ar_ready),
        .r_valid_o  (r_valid),
        .r_o        (r),
        .aw_ready_o (aw_ready),
        .w_ready_o  (w_ready),
        .b_valid_o  (b_valid),
        .b_resp_o   (b_resp)
    );

endmodule

`default_nettype wire

//--- hw/axi_slave_mem.sv
// axi slave word memory
`default_nettype none

module axi_slave_mem
    import axi_pkg::*;
    import mem_pkg::*;
(
    input  wire       clk,
    input  wire       arst_n_i,
    input  wire       ar_valid_i,
    input  axi_ar_t   ar_i,
    input  wire       r_ready_i,
    input  wire       aw_valid_i,
    input  axi_aw_t   aw_i,
    input  wire       w_valid_i,
    input  axi_w_t    w_i,
    input  wire       b_ready_i,
    output logic      ar_ready_o,
    output logic      r_valid_o,
    output axi_r_t    r_o,
    output logic      aw_ready_o,
    output logic      w_ready_o,
    output logic      b_valid_o,
    output axi_resp_e b_resp_o
);

    axi_data_t mem_q [MEM_WORDS];

    // read burst state
    axi_addr_t rd_addr_q;
    axi_len_t  rd_cnt_q;     // beats left after this one
    axi_id_t   rd_id_q;
    logic      rd_incr_q;
    logic      rd_size_bad_q;
    logic      rd_ok;
    // write state
    axi_addr_t wr_addr_q;
    axi_data_t wr_data_q;
    axi_strb_t wr_strb_q;
    logic      wr_last_q;
    logic      aw_got_q;
    logic      w_got_q;
    logic      wr_go;
    logic      wr_ok;

    function automatic word_idx_t word_of(axi_addr_t addr);
        return addr[$clog2(AXI_STRB_W) +: WORD_IDX_W];
    endfunction

    assign rd_ok = (rd_addr_q < MEM_BYTES) && !rd_size_bad_q;
    assign wr_go = aw_got_q && w_got_q && !b_valid_o;   // both halves in
    assign wr_ok = (wr_addr_q < MEM_BYTES) && wr_last_q;

    assign r_o.data = rd_ok ? mem_q[word_of(rd_addr_q)] : '0;   // zero on error
    assign r_o.resp = rd_ok ? OKAY : SLVERR;
    assign r_o.last = (rd_cnt_q == '0);
    assign r_o.id   = rd_id_q;

    // byte writes under strobe, out of range writes dropped
    always_ff @(posedge clk) begin
        if (wr_go && wr_ok) begin
            for (int i = 0; i < AXI_STRB_W; i++) begin
                if (wr_strb_q[i]) begin
                    mem_q[word_of(wr_addr_q)][i*8 +: 8] <= wr_data_q[i*8 +: 8];
                end
            end
        end
        if (aw_valid_i && aw_ready_o) begin
            wr_addr_q <= aw_i.addr;
        end
        if (w_valid_i && w_ready_o) begin
            wr_data_q <= w_i.data;
            wr_strb_q <= w_i.strb;
            wr_last_q <= w_i.last;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ar_ready_o    <= 1'b0;
            r_valid_o     <= 1'b0;
            rd_addr_q     <= '0;
            rd_cnt_q      <= '0;
            rd_id_q       <= '0;
            rd_incr_q     <= 1'b0;
            rd_size_bad_q <= 1'b0;
            aw_ready_o    <= 1'b0;
            w_ready_o     <= 1'b0;
            aw_got_q      <= 1'b0;
            w_got_q       <= 1'b0;
            b_valid_o     <= 1'b0;
            b_resp_o      <= OKAY;
        end else begin
            // ready one cycle after valid, one pulse per handshake
            ar_ready_o <= ar_valid_i && !ar_ready_o && !r_valid_o;
            aw_ready_o <= aw_valid_i && !aw_ready_o && !aw_got_q && !b_valid_o;
            w_ready_o  <= w_valid_i && !w_ready_o && !w_got_q && !b_valid_o;
            if (ar_valid_i && ar_ready_o) begin
                rd_addr_q     <= ar_i.addr;
                rd_cnt_q      <= ar_i.len;
                rd_id_q       <= ar_i.id;
                rd_incr_q     <= (ar_i.burst == AXI_BURST_INCR);
                rd_size_bad_q <= (ar_i.size != AXI_SIZE_8B);
                r_valid_o     <= 1'b1;   // first beat next cycle
            end else if (r_valid_o && r_ready_i) begin
                if (rd_cnt_q == '0) begin
                    r_valid_o <= 1'b0;   // burst done
                end else begin
                    rd_cnt_q <= rd_cnt_q - 1'b1;
                    if (rd_incr_q) begin
                        rd_addr_q <= rd_addr_q + AXI_STRB_W;
                    end
                end
            end
            if (aw_valid_i && aw_ready_o) begin
                aw_got_q <= 1'b1;
            end
            if (w_valid_i && w_ready_o) begin
                w_got_q <= 1'b1;
            end
            if (wr_go) begin
                aw_got_q  <= 1'b0;
                w_got_q   <= 1'b0;
                b_valid_o <= 1'b1;
                b_resp_o  <= wr_ok ? OKAY : SLVERR;
            end else if (b_valid_o && b_ready_i) begin
                b_valid_o <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/axi_master_bridge.sv
// request to axi master bridge
`default_nettype none

module axi_master_bridge
    import axi_pkg::*;
    import mem_pkg::*;
(
    input  wire       clk,
    input  wire       arst_n_i,
    input  wire       gnt_valid_i,
    input  mem_req_t  gnt_req_i,
    input  wire       ar_ready_i,
    input  wire       r_valid_i,
    input  axi_r_t    r_i,
    input  wire       aw_ready_i,
    input  wire       w_ready_i,
    input  wire       b_valid_i,
    input  axi_resp_e b_resp_i,
    output logic      busy_o,
    output logic      rsp_valid_o,
    output mem_rsp_t  rsp_o,
    output logic      ar_valid_o,
    output axi_ar_t   ar_o,
    output logic      r_ready_o,
    output logic      aw_valid_o,
    output axi_aw_t   aw_o,
    output logic      w_valid_o,
    output axi_w_t    w_o,
    output logic      b_ready_o
);

    typedef enum logic [2:0] {
        IDLE,
        READ_ADDR,
        READ_DATA,
        WRITE_REQ,
        WRITE_RESP,
        RESPOND
    } state_e;

    state_e    state_q;
    mem_req_t  req_q;       // held for the whole transaction
    line_t     line_q;      // gathered read beats
    logic      err_q;
    beat_idx_t beat_q;
    logic      aw_done_q;   // address taken this write
    logic      w_done_q;    // data taken this write
    logic      aw_fire;
    logic      w_fire;
    logic      r_bad;

    assign aw_fire = aw_valid_o && aw_ready_i;
    assign w_fire  = w_valid_o && w_ready_i;
    assign r_bad   = (r_i.resp != OKAY) || (r_i.id != axi_id_t'(req_q.client));

    // channel payloads come straight from the held request
    always_comb begin
        ar_o.addr  = req_q.addr;
        ar_o.len   = (req_q.client == CLIENT_FETCH) ? axi_len_t'(LINE_BEATS - 1) : '0;
        ar_o.size  = AXI_SIZE_8B;
        ar_o.burst = AXI_BURST_INCR;
        ar_o.id    = axi_id_t'(req_q.client);
        aw_o.addr  = req_q.addr;
        w_o.data   = req_q.wdata;
        w_o.strb   = req_q.wmask;
        w_o.last   = 1'b1;
    end

    assign busy_o      = (state_q != IDLE);
    assign ar_valid_o  = (state_q == READ_ADDR);
    assign r_ready_o   = (state_q == READ_DATA);
    assign aw_valid_o  = (state_q == WRITE_REQ) && !aw_done_q;
    assign w_valid_o   = (state_q == WRITE_REQ) && !w_done_q;
    assign b_ready_o   = (state_q == WRITE_RESP);
    assign rsp_valid_o = (state_q == RESPOND);

    // errored reads hand back zeros
    assign rsp_o.line   = err_q ? '0 : line_q;
    assign rsp_o.err    = err_q;
    assign rsp_o.client = req_q.client;

    always_ff @(posedge clk) begin
        if (state_q == IDLE && gnt_valid_i) begin
            req_q <= gnt_req_i;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= IDLE;
            line_q    <= '0;
            err_q     <= 1'b0;
            beat_q    <= '0;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (gnt_valid_i) begin
                        line_q    <= '0;   // stores answer with zero data
                        err_q     <= 1'b0;
                        beat_q    <= '0;
                        aw_done_q <= 1'b0;
                        w_done_q  <= 1'b0;
                        state_q   <= gnt_req_i.we ? WRITE_REQ : READ_ADDR;
                    end
                end
                READ_ADDR: begin
                    if (ar_ready_i) begin
                        state_q <= READ_DATA;
                    end
                end
                READ_DATA: begin
                    if (r_valid_i) begin
                        line_q[beat_q*AXI_DATA_W +: AXI_DATA_W] <= r_i.data;
                        err_q  <= err_q | r_bad;
                        beat_q <= beat_q + 1'b1;
                        if (r_i.last) begin
                            state_q <= RESPOND;
                        end
                    end
                end
                WRITE_REQ: begin
                    if (aw_fire) begin
                        aw_done_q <= 1'b1;
                    end
                    if (w_fire) begin
                        w_done_q <= 1'b1;
                    end
                    // both channels may finish in different cycles
                    if ((aw_done_q || aw_fire) && (w_done_q || w_fire)) begin
                        state_q <= WRITE_RESP;
                    end
                end
                WRITE_RESP: begin
                    if (b_valid_i) begin
                        err_q   <= err_q | (b_resp_i != OKAY);
                        state_q <= RESPOND;
                    end
                end
                RESPOND: state_q <= IDLE;   // single-cycle response strobe
                default: state_q <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/mem_arbiter.sv
// round-robin request arbiter
`default_nettype none

module mem_arbiter
    import axi_pkg::*;
    import mem_pkg::*;
(
    input  wire       clk,
    input  wire       arst_n_i,
    input  wire       fetch_req_i,    // one-cycle strobe
    input  axi_addr_t fetch_addr_i,
    input  wire       data_req_i,     // one-cycle strobe
    input  wire       data_we_i,
    input  axi_addr_t data_addr_i,
    input  axi_data_t data_wdata_i,
    input  axi_strb_t data_wmask_i,
    input  wire       busy_i,         // bridge still working
    output logic      gnt_valid_o,
    output mem_req_t  gnt_req_o
);

    logic      fetch_pend_q;
    axi_addr_t fetch_addr_q;   // payload, no reset
    logic      data_pend_q;
    mem_req_t  data_req_q;     // payload, no reset
    client_e   last_q;         // client granted most recently
    logic      pick_fetch;
    mem_req_t  fetch_req;

    // fetch always reads a full line
    always_comb begin
        fetch_req        = '0;
        fetch_req.we     = 1'b0;
        fetch_req.addr   = fetch_addr_q;
        fetch_req.client = CLIENT_FETCH;
    end

    // fetch wins if alone, or if data went last
    assign pick_fetch  = fetch_pend_q && (!data_pend_q || last_q == CLIENT_DATA);
    assign gnt_valid_o = !busy_i && (fetch_pend_q || data_pend_q);
    assign gnt_req_o   = pick_fetch ? fetch_req : data_req_q;

    always_ff @(posedge clk) begin
        if (fetch_req_i) begin
            fetch_addr_q <= fetch_addr_i;
        end
        if (data_req_i) begin
            data_req_q.we     <= data_we_i;
            data_req_q.addr   <= data_addr_i;
            data_req_q.wdata  <= data_wdata_i;
            data_req_q.wmask  <= data_wmask_i;
            data_req_q.client <= CLIENT_DATA;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fetch_pend_q <= 1'b0;
            data_pend_q  <= 1'b0;
            last_q       <= CLIENT_DATA;   // so fetch takes the first tie
        end else begin
            // a new strobe only comes after the old response, no overlap
            if (fetch_req_i) begin
                fetch_pend_q <= 1'b1;
            end else if (gnt_valid_o && pick_fetch) begin
                fetch_pend_q <= 1'b0;
            end
            if (data_req_i) begin
                data_pend_q <= 1'b1;
            end else if (gnt_valid_o && !pick_fetch) begin
                data_pend_q <= 1'b0;
            end
            if (gnt_valid_o) begin
                last_q <= pick_fetch ? CLIENT_FETCH : CLIENT_DATA;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/mem_pkg.sv
// memory client types
`default_nettype none

package mem_pkg;

    import axi_pkg::*;

    localparam int LINE_BEATS = 2;                        // beats per fetch line
    localparam int MEM_WORDS  = 256;                      // 64-bit words
    localparam int MEM_BYTES  = MEM_WORDS * AXI_STRB_W;   // first illegal byte address
    localparam int WORD_IDX_W = $clog2(MEM_WORDS);
    localparam int BEAT_IDX_W = $clog2(LINE_BEATS);

    typedef logic [LINE_BEATS*AXI_DATA_W-1:0] line_t;     // beat 0 in the low half
    typedef logic [WORD_IDX_W-1:0]            word_idx_t;
    typedef logic [BEAT_IDX_W-1:0]            beat_idx_t;

    // also used as the axi id
    typedef enum logic {
        CLIENT_FETCH = 1'b0,
        CLIENT_DATA  = 1'b1
    } client_e;

    typedef struct packed {
        logic      we;       // store when set
        axi_addr_t addr;
        axi_data_t wdata;
        axi_strb_t wmask;
        client_e   client;
    } mem_req_t;

    typedef struct packed {
        line_t   line;       // loads use the low beat only
        logic    err;
        client_e client;
    } mem_rsp_t;

endpackage

`default_nettype wire

//--- hw/axi_pkg.sv
// axi channel definitions
`default_nettype none

package axi_pkg;

    localparam int AXI_ADDR_W = 32;
    localparam int AXI_DATA_W = 64;
    localparam int AXI_STRB_W = AXI_DATA_W / 8;   // one strobe per byte

    typedef logic [AXI_ADDR_W-1:0] axi_addr_t;    // byte address
    typedef logic [AXI_DATA_W-1:0] axi_data_t;    // one beat
    typedef logic [AXI_STRB_W-1:0] axi_strb_t;    // byte lanes
    typedef logic [7:0]            axi_len_t;     // beats minus one
    typedef logic [2:0]            axi_size_t;    // log2 of beat bytes
    typedef logic [1:0]            axi_burst_t;
    typedef logic [0:0]            axi_id_t;      // carries the client number

    localparam axi_size_t  AXI_SIZE_8B    = 3'b011;
    localparam axi_burst_t AXI_BURST_INCR = 2'b01;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_e;

    // read address, id rides along so the slave can echo it on r
    typedef struct packed {
        axi_addr_t  addr;
        axi_len_t   len;
        axi_size_t  size;
        axi_burst_t burst;
        axi_id_t    id;
    } axi_ar_t;

    typedef struct packed {
        axi_addr_t addr;
    } axi_aw_t;

    typedef struct packed {
        axi_data_t data;
        axi_strb_t strb;
        logic      last;   // always set, single beat writes
    } axi_w_t;

    typedef struct packed {
        axi_data_t data;
        axi_resp_e resp;
        logic      last;
        axi_id_t   id;
    } axi_r_t;

endpackage

`default_nettype wire
